/* all.f */
+incdir+verif
hdl/ecc_pkg.sv
hdl/key_scanner.sv
hdl/point_sequencer.sv
hdl/point_datapath.sv
hdl/ecc_scalar_mult.sv
verif/tb_ecc_scalar_mult.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scalar multiplier testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_ecc_scalar_mult -o tb_ecc_scalar_mult
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ecc_scalar_mult > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

/* verif/ecc_field_model.svh */
`ifndef ECC_FIELD_MODEL_SVH
`define ECC_FIELD_MODEL_SVH

localparam ecc_pkg::field_t FIELD_P = 32'hffff_fffb;   // largest 32-bit prime

function automatic ecc_pkg::field_t add_mod(input ecc_pkg::field_t x,
                                            input ecc_pkg::field_t y);
    return ecc_pkg::field_t'((64'(x) + 64'(y)) % 64'(FIELD_P));
endfunction

function automatic ecc_pkg::field_t sub_mod(input ecc_pkg::field_t x,
                                            input ecc_pkg::field_t y);
    return ecc_pkg::field_t'((64'(x) + 64'(FIELD_P) - 64'(y)) % 64'(FIELD_P));
endfunction

function automatic ecc_pkg::field_t mul_mod(input ecc_pkg::field_t x,
                                            input ecc_pkg::field_t y);
    return ecc_pkg::field_t'((64'(x) * 64'(y)) % 64'(FIELD_P));
endfunction

function automatic ecc_pkg::field_t pow_mod(input ecc_pkg::field_t b, input logic [31:0] e);
    ecc_pkg::field_t r;
    ecc_pkg::field_t sq;
    r = 32'd1;
    sq = b;
    for (int i = 0; i < 32; i++)
    begin
        if (e[i])
            r = mul_mod(r, sq);
        sq = mul_mod(sq, sq);
    end
    return r;
endfunction

function automatic ecc_pkg::field_t div_mod(input ecc_pkg::field_t x,
                                            input ecc_pkg::field_t y);
    if (y == '0)
        return '0;                                   // zero divisor gives zero
    return mul_mod(x, pow_mod(y, FIELD_P - 32'd2));  // fermat inverse
endfunction

function automatic ecc_pkg::field_t field_op(input ecc_pkg::op_e op, input ecc_pkg::field_t x,
                                             input ecc_pkg::field_t y);
    case (op)
        ecc_pkg::op_add: return add_mod(x, y);
        ecc_pkg::op_sub: return sub_mod(x, y);
        ecc_pkg::op_mul: return mul_mod(x, y);
        default:         return div_mod(x, y);
    endcase
endfunction

// affine doubling, lambda = (3x^2 + a) / 2y
function automatic void double_point(inout ecc_pkg::field_t x, inout ecc_pkg::field_t y,
                                     input ecc_pkg::field_t ca);
    ecc_pkg::field_t lam;
    ecc_pkg::field_t x3;
    lam = div_mod(add_mod(mul_mod(32'd3, mul_mod(x, x)), ca), add_mod(y, y));
    x3 = sub_mod(sub_mod(mul_mod(lam, lam), x), x);
    y = sub_mod(mul_mod(lam, sub_mod(x, x3)), y);
    x = x3;
endfunction

function automatic void add_points(inout ecc_pkg::field_t qx, inout ecc_pkg::field_t qy,
                                   input ecc_pkg::field_t px, input ecc_pkg::field_t py);
    ecc_pkg::field_t lam;
    ecc_pkg::field_t x3;
    lam = div_mod(sub_mod(py, qy), sub_mod(px, qx));
    x3 = sub_mod(sub_mod(mul_mod(lam, lam), qx), px);
    qy = sub_mod(mul_mod(lam, sub_mod(qx, x3)), qy);
    qx = x3;
endfunction

// left to right, top bit of k always taken as one
function automatic void scalar_mult(input ecc_pkg::key_t k, input ecc_pkg::field_t px,
                                    input ecc_pkg::field_t py, input ecc_pkg::field_t ca,
                                    output ecc_pkg::field_t rx, output ecc_pkg::field_t ry);
    rx = px;
    ry = py;
    for (int i = ecc_pkg::KEY_W - 2; i >= 0; i--)
    begin
        double_point(rx, ry, ca);
        if (k[i])
            add_points(rx, ry, px, py);
    end
endfunction

`endif

/* verif/tb_ecc_scalar_mult.sv */
`timescale 1ns/10ps

module tb_ecc_scalar_mult;

    localparam int CLK_PERIOD     = 40;
    localparam int NUM_RANDOM     = 30;
    localparam int TIMEOUT_CYCLES = 60000;   // 33 runs of 147 ops at 10 cycles each plus margin

    logic            i_clk = 1'b0;
    logic            i_reset;
    logic            i_start;
    logic            i_op_done = 1'b0;
    ecc_pkg::key_t   i_scalar;
    ecc_pkg::field_t i_px, i_py, i_curve_a;
    ecc_pkg::field_t i_op_result = '0;
    logic            o_busy, o_done, o_op_req;
    ecc_pkg::op_e    o_op_sel;
    ecc_pkg::field_t o_opnd_a, o_opnd_b, o_qx, o_qy;

    int              value_errs = 0;
    int              proto_errs = 0;
    int              cycles = 0;
    int              total_reqs = 0;
    int              low_run = 0;            // req low cycles since last request
    int              resp_wait = -1;         // -1 with nothing pending
    bit              fresh = 1'b1;           // next request opens a run
    logic            op_req_q = 1'b0;
    ecc_pkg::op_e    held_sel;
    ecc_pkg::field_t held_a, held_b, resp_val;

    `include "ecc_field_model.svh"

    ecc_scalar_mult i_dut (.*);

    initial
    begin
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, o_done never came", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_field(input string name, input ecc_pkg::field_t got,
                               input ecc_pkg::field_t exp);
        assert (got == exp)
        else
        begin
            value_errs++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        assert (got == exp)
        else
        begin
            value_errs++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // field unit with 0 to 7 cycles of latency
    always @(posedge i_clk)
    begin
        i_op_done <= 1'b0;
        if (!o_busy)
            fresh = 1'b1;
        if (o_op_req && !op_req_q)
        begin
            assert (fresh || low_run == 1)
            else
            begin
                proto_errs++;
                $display("request low for %0d cycles between operations at %0t", low_run, $time);
            end
            fresh = 1'b0;
            low_run = 0;
            total_reqs++;
            held_sel = o_op_sel;
            held_a = o_opnd_a;
            held_b = o_opnd_b;
            resp_val = field_op(o_op_sel, o_opnd_a, o_opnd_b);
            resp_wait = $urandom_range(7, 0);
        end
        else if (o_op_req)
        begin
            assert (o_op_sel == held_sel)
            else
            begin
                value_errs++;
                $display("[FAIL] %0t o_op_sel got %0d expected %0d", $time, o_op_sel, held_sel);
            end
            check_field("o_opnd_a", o_opnd_a, held_a);
            check_field("o_opnd_b", o_opnd_b, held_b);
        end
        else
            low_run++;
        if (resp_wait == 0)
        begin
            i_op_done <= 1'b1;
            i_op_result <= resp_val;
        end
        if (resp_wait >= 0)
            resp_wait--;
        op_req_q = o_op_req;
    end

    task automatic run_mult(input ecc_pkg::key_t k, input bit restart);
        ecc_pkg::field_t px, py, ca, exp_x, exp_y;
        ecc_pkg::key_t   stray_k;
        ecc_pkg::field_t stray_x, stray_y;
        int reqs_before;
        int exp_reqs;
        px = ecc_pkg::field_t'($urandom % FIELD_P);
        py = ecc_pkg::field_t'($urandom % FIELD_P);
        ca = ecc_pkg::field_t'($urandom % FIELD_P);
        stray_k = ecc_pkg::key_t'($urandom);
        stray_x = $urandom;
        stray_y = $urandom;
        scalar_mult(k, px, py, ca, exp_x, exp_y);
        // 12 ops per doubling plus 9 per set bit below the top
        exp_reqs = ecc_pkg::KEY_STEPS * 12 + 9 * $countones(k[ecc_pkg::KEY_STEPS-1:0]);
        reqs_before = total_reqs;
        i_scalar <= k;
        i_px <= px;
        i_py <= py;
        i_curve_a <= ca;
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        if (restart)
        begin
            repeat (20) @(posedge i_clk);
            check_level("o_busy", o_busy, 1'b1);
            i_scalar <= stray_k;
            i_px <= stray_x;
            i_py <= stray_y;
            i_start <= 1'b1;
            @(posedge i_clk);
            i_start <= 1'b0;
        end
        @(posedge i_clk);
        while (!o_done)
            @(posedge i_clk);
        check_field("o_qx", o_qx, exp_x);
        check_field("o_qy", o_qy, exp_y);
        assert (total_reqs - reqs_before == exp_reqs)
        else
        begin
            proto_errs++;
            $display("scalar %h issued %0d operations instead of %0d",
                     k, total_reqs - reqs_before, exp_reqs);
        end
    endtask

    initial
    begin
        void'($urandom(32'h53c371ab));
        i_reset <= 1'b1;
        i_start <= 1'b0;
        i_scalar <= '0;
        i_px <= '0;
        i_py <= '0;
        i_curve_a <= '0;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        @(posedge i_clk);
        check_level("o_busy", o_busy, 1'b0);
        check_level("o_done", o_done, 1'b0);
        check_level("o_op_req", o_op_req, 1'b0);
        run_mult(8'h00, 1'b0);                          // doublings only
        run_mult(8'hff, 1'b0);                          // add after every doubling
        run_mult(ecc_pkg::key_t'($urandom), 1'b1);      // stray start while busy
        for (int n = 0; n < NUM_RANDOM; n++)
            run_mult(ecc_pkg::key_t'($urandom), 1'b0);
        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if ((value_errs + proto_errs) == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* hdl/ecc_scalar_mult.sv */
`timescale 1ns/10ps

module ecc_scalar_mult
(
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_start,
    input  logic            i_op_done,
    input  ecc_pkg::key_t   i_scalar,
    input  ecc_pkg::field_t i_px,
    input  ecc_pkg::field_t i_py,
    input  ecc_pkg::field_t i_curve_a,
    input  ecc_pkg::field_t i_op_result,
    output logic            o_busy,
    output logic            o_done,
    output logic            o_op_req,
    output ecc_pkg::op_e    o_op_sel,
    output ecc_pkg::field_t o_opnd_a,
    output ecc_pkg::field_t o_opnd_b,
    output ecc_pkg::field_t o_qx,
    output ecc_pkg::field_t o_qy
);

    logic              key_load;
    logic              key_next;
    logic              key_bit;
    logic              key_last;
    logic              dp_load;
    logic              dp_wr;
    logic              dp_commit;
    ecc_pkg::reg_sel_e src_a;
    ecc_pkg::reg_sel_e src_b;
    ecc_pkg::reg_sel_e dst;

    key_scanner i_key_scanner
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_load   (key_load),
        .i_next   (key_next),
        .i_scalar (i_scalar),
        .o_bit    (key_bit),
        .o_last   (key_last)
    );

    point_sequencer i_point_sequencer
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_start    (i_start),
        .i_op_done  (i_op_done),
        .i_bit      (key_bit),
        .i_last     (key_last),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_op_req   (o_op_req),
        .o_wr       (dp_wr),
        .o_load     (dp_load),
        .o_commit   (dp_commit),
        .o_key_load (key_load),
        .o_key_next (key_next),
        .o_op_sel   (o_op_sel),
        .o_src_a    (src_a),
        .o_src_b    (src_b),
        .o_dst      (dst)
    );

    point_datapath i_point_datapath
    (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_load    (dp_load),
        .i_wr      (dp_wr),
        .i_commit  (dp_commit),
        .i_px      (i_px),
        .i_py      (i_py),
        .i_curve_a (i_curve_a),
        .i_result  (i_op_result),
        .i_src_a   (src_a),
        .i_src_b   (src_b),
        .i_dst     (dst),
        .o_opnd_a  (o_opnd_a),
        .o_opnd_b  (o_opnd_b),
        .o_qx      (o_qx),
        .o_qy      (o_qy)
    );

endmodule

/* hdl/point_datapath.sv */
`timescale 1ns/10ps

module point_datapath
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_load,
    input  logic              i_wr,
    input  logic              i_commit,
    input  ecc_pkg::field_t   i_px,
    input  ecc_pkg::field_t   i_py,
    input  ecc_pkg::field_t   i_curve_a,
    input  ecc_pkg::field_t   i_result,
    input  ecc_pkg::reg_sel_e i_src_a,
    input  ecc_pkg::reg_sel_e i_src_b,
    input  ecc_pkg::reg_sel_e i_dst,
    output ecc_pkg::field_t   o_opnd_a,
    output ecc_pkg::field_t   o_opnd_b,
    output ecc_pkg::field_t   o_qx,
    output ecc_pkg::field_t   o_qy
);

    ecc_pkg::field_t qx, qy;                   // working point Q
    ecc_pkg::field_t px, py;                   // base point P
    ecc_pkg::field_t a;
    ecc_pkg::field_t t1, t2, t3;
    ecc_pkg::field_t bank [ecc_pkg::NUM_REGS];
    logic [ecc_pkg::NUM_REGS-1:0] wr_en;

    // read view indexed by select code
    assign bank[ecc_pkg::sel_qx] = qx;
    assign bank[ecc_pkg::sel_qy] = qy;
    assign bank[ecc_pkg::sel_px] = px;
    assign bank[ecc_pkg::sel_py] = py;
    assign bank[ecc_pkg::sel_a]  = a;
    assign bank[ecc_pkg::sel_t1] = t1;
    assign bank[ecc_pkg::sel_t2] = t2;
    assign bank[ecc_pkg::sel_t3] = t3;

    assign o_opnd_a = bank[i_src_a];
    assign o_opnd_b = bank[i_src_b];

    always_comb
    begin
        wr_en = '0;
        if (i_wr)
            wr_en[i_dst] = 1'b1;
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            qx <= '0;
            qy <= '0;
        end
        else if (i_load)
        begin
            qx <= i_px;                        // Q starts at P
            qy <= i_py;
        end
        else
        begin
            if (i_commit)
                qx <= t2;                      // x3 moves with y3
            else if (wr_en[ecc_pkg::sel_qx])
                qx <= i_result;
            if (wr_en[ecc_pkg::sel_qy])
                qy <= i_result;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            px <= i_px;
            py <= i_py;
            a  <= i_curve_a;
        end
        else
        begin
            if (wr_en[ecc_pkg::sel_px])
                px <= i_result;
            if (wr_en[ecc_pkg::sel_py])
                py <= i_result;
            if (wr_en[ecc_pkg::sel_a])
                a <= i_result;
        end
        if (wr_en[ecc_pkg::sel_t1])
            t1 <= i_result;                    // lambda
        if (wr_en[ecc_pkg::sel_t2])
            t2 <= i_result;
        if (wr_en[ecc_pkg::sel_t3])
            t3 <= i_result;
    end

    assign o_qx = qx;
    assign o_qy = qy;

endmodule

/* hdl/point_sequencer.sv */
`timescale 1ns/10ps

module point_sequencer
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_start,
    input  logic              i_op_done,
    input  logic              i_bit,
    input  logic              i_last,
    output logic              o_busy,
    output logic              o_done,
    output logic              o_op_req,
    output logic              o_wr,
    output logic              o_load,
    output logic              o_commit,
    output logic              o_key_load,
    output logic              o_key_next,
    output ecc_pkg::op_e      o_op_sel,
    output ecc_pkg::reg_sel_e o_src_a,
    output ecc_pkg::reg_sel_e o_src_b,
    output ecc_pkg::reg_sel_e o_dst
);

    localparam int SEL_W = $bits(ecc_pkg::reg_sel_e);
    localparam int CTL_W = $bits(ecc_pkg::op_e) + 3 * SEL_W;

    ecc_pkg::step_e   state;
    ecc_pkg::step_e   state_n;
    logic             req_r;
    logic             req_n;
    logic             final_step;
    logic [CTL_W-1:0] step_ctl;        // {op, src_a, src_b, dst}

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state <= ecc_pkg::st_idle;
            req_r <= 1'b0;
        end
        else
        begin
            state <= state_n;
            req_r <= req_n;
        end
    end

    always_comb
    begin
        state_n = state;
        req_n   = req_r;
        case (state)
            ecc_pkg::st_idle:
            begin
                if (i_start)
                    state_n = ecc_pkg::st_load;
            end
            ecc_pkg::st_load:
            begin
                state_n = ecc_pkg::dbl_0;
                req_n   = 1'b1;
            end
            ecc_pkg::st_next:
            begin
                if (i_last)
                begin
                    state_n = ecc_pkg::st_idle;
                end
                else
                begin
                    state_n = ecc_pkg::dbl_0;
                    req_n   = 1'b1;
                end
            end
            default:
            begin
                if (!req_r)
                begin
                    req_n = 1'b1;                      // end of the gap cycle
                end
                else if (i_op_done)
                begin
                    req_n = 1'b0;
                    if ((state == ecc_pkg::dbl_11) && !i_bit)
                        state_n = ecc_pkg::st_next;    // skip the addition
                    else
                        state_n = ecc_pkg::step_e'(state + 1'b1);
                end
            end
        endcase
    end

    // per-step opcode and register selects
    always_comb
    begin
        case (state)
            ecc_pkg::dbl_0:
                step_ctl = {ecc_pkg::op_mul, ecc_pkg::sel_qx, ecc_pkg::sel_qx, ecc_pkg::sel_t2};
            ecc_pkg::dbl_1:
                step_ctl = {ecc_pkg::op_add, ecc_pkg::sel_t2, ecc_pkg::sel_t2, ecc_pkg::sel_t3};
            ecc_pkg::dbl_2:
                step_ctl = {ecc_pkg::op_add, ecc_pkg::sel_t3, ecc_pkg::sel_t2, ecc_pkg::sel_t2};
            ecc_pkg::dbl_3:
                step_ctl = {ecc_pkg::op_add, ecc_pkg::sel_t2, ecc_pkg::sel_a, ecc_pkg::sel_t2};
            ecc_pkg::dbl_4:
                step_ctl = {ecc_pkg::op_add, ecc_pkg::sel_qy, ecc_pkg::sel_qy, ecc_pkg::sel_t3};
            ecc_pkg::dbl_5:
                step_ctl = {ecc_pkg::op_div, ecc_pkg::sel_t2, ecc_pkg::sel_t3, ecc_pkg::sel_t1};
            ecc_pkg::dbl_6:
                step_ctl = {ecc_pkg::op_mul, ecc_pkg::sel_t1, ecc_pkg::sel_t1, ecc_pkg::sel_t2};
            ecc_pkg::dbl_7:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_t2, ecc_pkg::sel_qx, ecc_pkg::sel_t2};
            ecc_pkg::dbl_8:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_t2, ecc_pkg::sel_qx, ecc_pkg::sel_t2};
            ecc_pkg::dbl_9:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_qx, ecc_pkg::sel_t2, ecc_pkg::sel_t3};
            ecc_pkg::dbl_10:
                step_ctl = {ecc_pkg::op_mul, ecc_pkg::sel_t1, ecc_pkg::sel_t3, ecc_pkg::sel_t3};
            ecc_pkg::dbl_11:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_t3, ecc_pkg::sel_qy, ecc_pkg::sel_qy};
            ecc_pkg::add_0:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_py, ecc_pkg::sel_qy, ecc_pkg::sel_t2};
            ecc_pkg::add_1:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_px, ecc_pkg::sel_qx, ecc_pkg::sel_t3};
            ecc_pkg::add_2:
                step_ctl = {ecc_pkg::op_div, ecc_pkg::sel_t2, ecc_pkg::sel_t3, ecc_pkg::sel_t1};
            ecc_pkg::add_3:
                step_ctl = {ecc_pkg::op_mul, ecc_pkg::sel_t1, ecc_pkg::sel_t1, ecc_pkg::sel_t2};
            ecc_pkg::add_4:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_t2, ecc_pkg::sel_qx, ecc_pkg::sel_t2};
            ecc_pkg::add_5:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_t2, ecc_pkg::sel_px, ecc_pkg::sel_t2};
            ecc_pkg::add_6:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_qx, ecc_pkg::sel_t2, ecc_pkg::sel_t3};
            ecc_pkg::add_7:
                step_ctl = {ecc_pkg::op_mul, ecc_pkg::sel_t1, ecc_pkg::sel_t3, ecc_pkg::sel_t3};
            ecc_pkg::add_8:
                step_ctl = {ecc_pkg::op_sub, ecc_pkg::sel_t3, ecc_pkg::sel_qy, ecc_pkg::sel_qy};
            default:
                step_ctl = {ecc_pkg::op_add, ecc_pkg::sel_qx, ecc_pkg::sel_qx, ecc_pkg::sel_t2};
        endcase
    end

    assign final_step = (state == ecc_pkg::dbl_11) || (state == ecc_pkg::add_8);

    assign o_op_sel = ecc_pkg::op_e'(step_ctl[CTL_W-1 -: 2]);
    assign o_src_a  = ecc_pkg::reg_sel_e'(step_ctl[3*SEL_W-1 -: SEL_W]);
    assign o_src_b  = ecc_pkg::reg_sel_e'(step_ctl[2*SEL_W-1 -: SEL_W]);
    assign o_dst    = ecc_pkg::reg_sel_e'(step_ctl[SEL_W-1:0]);

    assign o_op_req   = req_r;
    assign o_wr       = req_r && i_op_done;          // late done pulses dropped
    assign o_commit   = o_wr && final_step;
    assign o_load     = (state == ecc_pkg::st_idle) && i_start;
    assign o_key_load = o_load;
    assign o_key_next = (state == ecc_pkg::st_next) && !i_last;
    assign o_done     = (state == ecc_pkg::st_next) && i_last;
    assign o_busy     = (state != ecc_pkg::st_idle);

endmodule

/* hdl/key_scanner.sv */
`timescale 1ns/10ps

module key_scanner
(
    input  logic          i_clk,
    input  logic          i_reset,
    input  logic          i_load,
    input  logic          i_next,
    input  ecc_pkg::key_t i_scalar,
    output logic          o_bit,
    output logic          o_last
);

    logic [ecc_pkg::KEY_STEPS-1:0] key_sr;     // bits below the leading one
    ecc_pkg::key_cnt_t             remain;     // bits still to present

    // shift register, msb first
    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            key_sr <= i_scalar[ecc_pkg::KEY_STEPS-1:0];
        end
        else if (i_next)
        begin
            key_sr <= {key_sr[ecc_pkg::KEY_STEPS-2:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            remain <= '0;
        end
        else if (i_load)
        begin
            remain <= ecc_pkg::key_cnt_t'(ecc_pkg::KEY_STEPS);
        end
        else if (i_next && (remain != '0))
        begin
            remain <= remain - 1'b1;
        end
    end

    assign o_bit  = key_sr[ecc_pkg::KEY_STEPS-1];
    assign o_last = (remain == ecc_pkg::key_cnt_t'(1));   // current bit is final

endmodule

/* hdl/ecc_pkg.sv */
package ecc_pkg;

    localparam int FIELD_W   = 32;
    localparam int KEY_W     = 8;
    localparam int KEY_STEPS = KEY_W - 1;          // top bit taken as one
    localparam int KEY_CNT_W = $clog2(KEY_STEPS + 1);
    localparam int NUM_REGS  = 8;

    typedef logic [FIELD_W-1:0]   field_t;
    typedef logic [KEY_W-1:0]     key_t;
    typedef logic [KEY_CNT_W-1:0] key_cnt_t;

    // field unit opcodes
    typedef enum logic [1:0] {
        op_add = 2'b00,
        op_sub = 2'b01,
        op_mul = 2'b10,
        op_div = 2'b11
    } op_e;

    typedef enum logic [2:0] {
        sel_qx,
        sel_qy,
        sel_px,
        sel_py,
        sel_a,
        sel_t1,
        sel_t2,
        sel_t3
    } reg_sel_e;

    // order matters, steps advance by increment
    typedef enum logic [4:0] {
        st_idle,
        st_load,
        dbl_0, dbl_1, dbl_2, dbl_3,
        dbl_4, dbl_5, dbl_6, dbl_7,
        dbl_8, dbl_9, dbl_10, dbl_11,
        add_0, add_1, add_2,
        add_3, add_4, add_5,
        add_6, add_7, add_8,
        st_next
    } step_e;

endpackage
